//--- verilog/clkmon_pkg.sv
`default_nettype none

package clkmon_pkg;

	// Frequency words and running counts share one width
	parameter int FREQ_W = 32;

	typedef logic [FREQ_W-1:0] freq_t;	// Edges per gate window, or a raw count

	// Host read selector
	typedef enum logic [1:0] {
		RD_FREQ    = 2'd0,	// Frequency of rd_addr
		RD_WINDOWS = 2'd1,	// Completed windows
		RD_ALIVE   = 2'd2	// Nonzero channel mask
	} rd_op_e;

	// First window after reset only takes a baseline
	typedef enum logic {
		GATE_WARMUP  = 1'b0,
		GATE_MEASURE = 1'b1
	} gate_state_e;

endpackage

`default_nettype wire

//--- verilog/reset_sync.sv
`timescale 1ns/1ps
`default_nettype none

module reset_sync #(
	parameter int SYNC_LEN = 4
) (
	input  logic clk,
	input  logic rst,
	output logic sync_rst
);

	logic [SYNC_LEN-1:0] sr;

	// Loads all ones while rst is seen, then drains zeros in from the bottom
	always_ff @(posedge clk) begin
		if (rst) begin
			sr <= '1;
		end else begin
			sr <= {sr[SYNC_LEN-2:0], 1'b0};
		end
	end

	// Top stage clears last, so it is set while any stage is set
	assign sync_rst = sr[SYNC_LEN-1];

endmodule

`default_nettype wire

//--- verilog/edge_counter.sv
`timescale 1ns/1ps
`default_nettype none

module edge_counter (
	input  logic               clk,
	input  logic               rst,
	output clkmon_pkg::freq_t  cnt_gray
);

	// Known at power-up, even when clk never runs
	clkmon_pkg::freq_t cnt = '0;
	clkmon_pkg::freq_t gray_q = '0;
	clkmon_pkg::freq_t cnt_nxt;

	assign cnt_nxt = cnt + 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt    <= '0;
			gray_q <= '0;
		end else begin
			cnt    <= cnt_nxt;
			gray_q <= cnt_nxt ^ (cnt_nxt >> 1);	// One bit flips per edge
		end
	end

	assign cnt_gray = gray_q;

endmodule

`default_nettype wire

//--- verilog/gray_sync.sv
`timescale 1ns/1ps
`default_nettype none

module gray_sync (
	input  logic               hw,
	input  logic               rst,
	input  clkmon_pkg::freq_t  cnt_gray,
	output clkmon_pkg::freq_t  cnt_bin
);

	clkmon_pkg::freq_t meta_q;
	clkmon_pkg::freq_t sync_q;

	function automatic clkmon_pkg::freq_t gray2bin(input clkmon_pkg::freq_t g);
		clkmon_pkg::freq_t b;
		b[clkmon_pkg::FREQ_W-1] = g[clkmon_pkg::FREQ_W-1];
		for (int i = clkmon_pkg::FREQ_W - 2; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	always_ff @(posedge hw) begin
		if (rst) begin
			meta_q  <= '0;
			sync_q  <= '0;
			cnt_bin <= '0;
		end else begin
			meta_q  <= cnt_gray;	// Crosses from the fin domain
			sync_q  <= meta_q;
			cnt_bin <= gray2bin(sync_q);
		end
	end

endmodule

`default_nettype wire

//--- verilog/freq_gate.sv
`timescale 1ns/1ps
`default_nettype none

module freq_gate #(
	parameter int NCH    = 4,
	parameter int GATE_W = 10
) (
	input  logic                                hw,
	input  logic                                rst,
	input  logic [NCH*clkmon_pkg::FREQ_W-1:0]   cnt_vec,
	output logic [NCH*clkmon_pkg::FREQ_W-1:0]   freq_vec,
	output logic                                win_strobe
);

	localparam int W = clkmon_pkg::FREQ_W;

	logic [GATE_W-1:0]       gate_cnt;
	logic                    win_end;
	clkmon_pkg::gate_state_e state;
	logic [NCH*W-1:0]        base_vec;	// Counts at the previous window end

	// Free-running, wraps every 2**GATE_W cycles
	assign win_end = &gate_cnt;

	always_ff @(posedge hw) begin
		if (rst) begin
			gate_cnt   <= '0;
			state      <= clkmon_pkg::GATE_WARMUP;
			win_strobe <= 1'b0;
		end else begin
			gate_cnt   <= gate_cnt + 1'b1;
			win_strobe <= win_end && (state == clkmon_pkg::GATE_MEASURE);
			if (win_end) begin
				state <= clkmon_pkg::GATE_MEASURE;
			end
		end
	end

	genvar ch;
	generate
		for (ch = 0; ch < NCH; ch++) begin : g_ch
			always_ff @(posedge hw) begin
				if (win_end) begin
					// Wraps cleanly modulo 2**32
					if (state == clkmon_pkg::GATE_MEASURE) begin
						freq_vec[ch*W +: W] <= cnt_vec[ch*W +: W] - base_vec[ch*W +: W];
					end
					base_vec[ch*W +: W] <= cnt_vec[ch*W +: W];
				end
			end
		end
	endgenerate

endmodule

`default_nettype wire

//--- verilog/freq_regs.sv
`timescale 1ns/1ps
`default_nettype none

module freq_regs #(
	parameter int NCH = 4
) (
	input  logic                                hw,
	input  logic                                rst,
	input  logic [NCH*clkmon_pkg::FREQ_W-1:0]   freq_vec,
	input  logic                                win_strobe,
	input  logic                                rd_en,
	input  clkmon_pkg::rd_op_e                  rd_op,
	input  logic [$clog2(NCH)-1:0]              rd_addr,
	output clkmon_pkg::freq_t                   rd_data,
	output logic                                rd_valid,
	output logic                                window_done
);

	localparam int W = clkmon_pkg::FREQ_W;

	clkmon_pkg::freq_t freq_q [NCH];
	clkmon_pkg::freq_t win_tally;
	clkmon_pkg::freq_t rd_word;
	logic [NCH-1:0]    alive;

	always_ff @(posedge hw) begin
		if (rst) begin
			for (int i = 0; i < NCH; i++) begin
				freq_q[i] <= '0;
			end
			win_tally   <= '0;
			window_done <= 1'b0;
			rd_valid    <= 1'b0;
		end else begin
			if (win_strobe) begin
				for (int i = 0; i < NCH; i++) begin
					freq_q[i] <= freq_vec[i*W +: W];
				end
				win_tally <= win_tally + 1'b1;
			end
			window_done <= win_strobe;
			rd_valid    <= rd_en;	// No back-pressure
		end
	end

	genvar ch;
	generate
		for (ch = 0; ch < NCH; ch++) begin : g_alive
			assign alive[ch] = |freq_q[ch];
		end
	endgenerate

	always_comb begin
		rd_word = '0;
		case (rd_op)
			clkmon_pkg::RD_FREQ:    if (int'(rd_addr) < NCH) rd_word = freq_q[rd_addr];
			clkmon_pkg::RD_WINDOWS: rd_word = win_tally;
			clkmon_pkg::RD_ALIVE:   rd_word = clkmon_pkg::freq_t'(alive);
			default:                rd_word = '0;
		endcase
	end

	always_ff @(posedge hw) begin
		if (rd_en) begin
			rd_data <= rd_word;
		end
	end

endmodule

`default_nettype wire

//--- verilog/clkmon_top.sv
`timescale 1ns/1ps
`default_nettype none

module clkmon_top #(
	parameter int NCH      = 4,
	parameter int GATE_W   = 10,
	parameter int SYNC_LEN = 4
) (
	input  logic                    hw,
	input  logic                    rst,
	input  logic [NCH-1:0]          fin,
	input  logic                    rd_en,
	input  clkmon_pkg::rd_op_e      rd_op,
	input  logic [$clog2(NCH)-1:0]  rd_addr,
	output clkmon_pkg::freq_t       rd_data,
	output logic                    rd_valid,
	output logic                    window_done
);

	localparam int W = clkmon_pkg::FREQ_W;

	logic [NCH*W-1:0] cnt_vec;
	logic [NCH*W-1:0] freq_vec;
	logic             win_strobe;

	genvar ch;
	generate
		for (ch = 0; ch < NCH; ch++) begin : g_ch
			logic              fin_rst;
			clkmon_pkg::freq_t cnt_gray;	// fin domain
			clkmon_pkg::freq_t cnt_bin;	// hw domain

			reset_sync #(.SYNC_LEN(SYNC_LEN)) reset_sync_i (
				.clk      (fin[ch]),
				.rst      (rst),
				.sync_rst (fin_rst)
			);

			edge_counter edge_counter_i (
				.clk      (fin[ch]),
				.rst      (fin_rst),
				.cnt_gray (cnt_gray)
			);

			gray_sync gray_sync_i (
				.hw       (hw),
				.rst      (rst),
				.cnt_gray (cnt_gray),
				.cnt_bin  (cnt_bin)
			);

			assign cnt_vec[ch*W +: W] = cnt_bin;
		end
	endgenerate

	freq_gate #(.NCH(NCH), .GATE_W(GATE_W)) freq_gate_i (
		.hw         (hw),
		.rst        (rst),
		.cnt_vec    (cnt_vec),
		.freq_vec   (freq_vec),
		.win_strobe (win_strobe)
	);

	freq_regs #(.NCH(NCH)) freq_regs_i (
		.hw          (hw),
		.rst         (rst),
		.freq_vec    (freq_vec),
		.win_strobe  (win_strobe),
		.rd_en       (rd_en),
		.rd_op       (rd_op),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.rd_valid    (rd_valid),
		.window_done (window_done)
	);

endmodule

`default_nettype wire

//--- bench/clkmon_tb.sv
`timescale 1ns/1ps
`default_nettype none

module clkmon_tb;

	localparam int NCH          = 4;
	localparam int GATE_W       = 10;
	localparam int ADDR_W       = $clog2(NCH);
	localparam int WIN_CYCLES   = 1 << GATE_W;
	localparam int HW_PERIOD    = 4;
	localparam int RESET_CYCLES = 4;
	localparam int TOL          = 2;	// Phase and synchronizer slack
	localparam int WATCHDOG_NS  = 8 * WIN_CYCLES * HW_PERIOD + RESET_CYCLES * HW_PERIOD;

	logic               hw = 1'b0;
	logic               rst;
	logic [NCH-1:0]     fin;
	logic               rd_en;
	clkmon_pkg::rd_op_e rd_op;
	logic [ADDR_W-1:0]  rd_addr;
	clkmon_pkg::freq_t  rd_data;
	logic               rd_valid;
	logic               window_done;

	logic [31:0]        rng_state = 32'he70a4be9;
	int                 cyc_since_rst = 0;
	int                 win_seen = 0;	// window_done pulses since the last reset
	logic               en_prev = 1'b0;
	clkmon_pkg::freq_t  exp_word_q [$];
	clkmon_pkg::rd_op_e exp_op_q [$];
	int                 exp_addr_q [$];
	bit                 exp_tol_q [$];

	clkmon_top #(.NCH(NCH), .GATE_W(GATE_W)) dut_i (
		.hw          (hw),
		.rst         (rst),
		.fin         (fin),
		.rd_en       (rd_en),
		.rd_op       (rd_op),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.rd_valid    (rd_valid),
		.window_done (window_done)
	);

	function automatic int period_ps(input int ch);
		case (ch)
			0:       return 5000;
			1:       return 8000;
			2:       return 3000;
			default: return 0;	// Held low
		endcase
	endfunction

	// Window length over clock period, rounded
	function automatic clkmon_pkg::freq_t expected_freq(input int ch);
		longint win_ps;
		longint p;
		win_ps = longint'(WIN_CYCLES) * HW_PERIOD * 1000;
		p = period_ps(ch);
		if (p == 0) begin
			return '0;
		end
		return clkmon_pkg::freq_t'((win_ps + p / 2) / p);
	endfunction

	function automatic clkmon_pkg::freq_t alive_mask();
		clkmon_pkg::freq_t m;
		m = '0;
		for (int i = 0; i < NCH; i++) begin
			m[i] = (expected_freq(i) != 0);
		end
		return m;
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int rand_below(input int n);
		rng_state = lcg_next(rng_state);
		return int'(rng_state[30:16]) % n;
	endfunction

	initial begin
		forever #(HW_PERIOD / 2.0) hw = ~hw;
	end

	initial begin
		fin[0] = 1'b0;
		forever #(period_ps(0) / 2000.0) fin[0] = ~fin[0];
	end

	initial begin
		fin[1] = 1'b0;
		forever #(period_ps(1) / 2000.0) fin[1] = ~fin[1];
	end

	initial begin
		fin[2] = 1'b0;
		forever #(period_ps(2) / 2000.0) fin[2] = ~fin[2];
	end

	always @(posedge hw) begin
		if (rst) begin
			cyc_since_rst <= 0;
		end else begin
			cyc_since_rst <= cyc_since_rst + 1;
		end
	end

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Errors found");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_freq(input int addr, input clkmon_pkg::freq_t got,
			input clkmon_pkg::freq_t exp);
		longint diff;
		diff = longint'(got) - longint'(exp);
		if (diff > TOL || diff < -TOL) begin
			stop_run($sformatf("ERR at %0d ns: RD_FREQ ch %0d read %0d, expected %0d +/- %0d",
				$time, addr, got, exp, TOL));
		end
	endtask

	task automatic check_op_word(input clkmon_pkg::rd_op_e op, input int addr,
			input clkmon_pkg::freq_t got, input clkmon_pkg::freq_t exp);
		if (got !== exp) begin
			stop_run($sformatf("ERR at %0d ns: %s addr %0d read %0d, expected %0d",
				$time, op.name(), addr, got, exp));
		end
	endtask

	// Every strobe must be answered on the very next cycle
	always @(negedge hw) begin : compare_reads
		clkmon_pkg::freq_t  exp;
		clkmon_pkg::rd_op_e op;
		int                 addr;
		bit                 tol;
		if (rst) begin
			en_prev = 1'b0;
		end else if (rd_valid !== en_prev) begin
			stop_run(en_prev ? "rd_valid missing one cycle after rd_en"
				: "rd_valid raised without a read strobe");
		end else begin
			if (rd_valid === 1'b1) begin
				exp  = exp_word_q.pop_front();
				op   = exp_op_q.pop_front();
				addr = exp_addr_q.pop_front();
				tol  = exp_tol_q.pop_front();
				if (tol) begin
					check_freq(addr, rd_data, exp);
				end else begin
					check_op_word(op, addr, rd_data, exp);
				end
			end
			en_prev = rd_en;
		end
	end

	task automatic issue(input clkmon_pkg::rd_op_e op, input int addr,
			input clkmon_pkg::freq_t exp, input bit tol);
		rd_en   <= 1'b1;
		rd_op   <= op;
		rd_addr <= addr[ADDR_W-1:0];
		exp_word_q.push_back(exp);
		exp_op_q.push_back(op);
		exp_addr_q.push_back(addr);
		exp_tol_q.push_back(tol);
	endtask

	task automatic wait_reads_done();
		int n;
		n = 0;
		while (exp_word_q.size() != 0) begin
			@(negedge hw);
			n++;
			if (n > 4) begin
				stop_run("rd_valid never came back for an outstanding read");
			end
		end
	endtask

	task automatic read_word(input clkmon_pkg::rd_op_e op, input int addr,
			input clkmon_pkg::freq_t exp, input bit tol);
		@(posedge hw);
		issue(op, addr, exp, tol);
		@(posedge hw);
		rd_en <= 1'b0;
		wait_reads_done();
	endtask

	// All channels in shuffled order, random idle gaps between reads
	task automatic read_all_freq(input bit measured);
		int order [NCH];
		int j;
		int t;
		clkmon_pkg::freq_t exp;
		for (int i = 0; i < NCH; i++) begin
			order[i] = i;
		end
		for (int i = NCH - 1; i > 0; i--) begin
			j = rand_below(i + 1);
			t = order[i];
			order[i] = order[j];
			order[j] = t;
		end
		for (int i = 0; i < NCH; i++) begin
			repeat (rand_below(4)) @(posedge hw);
			exp = measured ? expected_freq(order[i]) : '0;
			read_word(clkmon_pkg::RD_FREQ, order[i], exp, exp != 0);
		end
	endtask

	// Back-to-back strobes; with NCH of 4 every rd_addr value names a channel
	task automatic read_burst();
		@(posedge hw);
		issue(clkmon_pkg::RD_FREQ, NCH - 1, expected_freq(NCH - 1), 1'b0);
		@(posedge hw);
		issue(clkmon_pkg::RD_WINDOWS, 0, clkmon_pkg::freq_t'(win_seen), 1'b0);
		@(posedge hw);
		issue(clkmon_pkg::RD_ALIVE, 0, alive_mask(), 1'b0);
		@(posedge hw);
		rd_en <= 1'b0;
		wait_reads_done();
	endtask

	task automatic wait_window(output int done_at);
		int n;
		n = 0;
		@(negedge hw);
		while (window_done !== 1'b1) begin
			@(negedge hw);
			n++;
			if (n > 2 * WIN_CYCLES + 64) begin
				stop_run("window_done did not arrive within two windows");
			end
		end
		win_seen++;
		done_at = cyc_since_rst;
	endtask

	// GATE_WARMUP eats the first window after reset
	task automatic check_warmup(input int done_at);
		if (done_at < 2 * WIN_CYCLES) begin
			stop_run($sformatf("ERR at %0d ns: first window_done %0d cycles after reset",
				$time, done_at));
		end
	endtask

	initial begin : stimulus
		int done_at;
		int prev_done;
		rst     = 1'b1;
		rd_en   = 1'b0;
		rd_op   = clkmon_pkg::RD_FREQ;
		rd_addr = '0;
		fin[3]  = 1'b0;	// Stopped channel
		repeat (RESET_CYCLES) @(posedge hw);
		rst <= 1'b0;

		read_all_freq(1'b0);
		read_word(clkmon_pkg::RD_WINDOWS, 0, '0, 1'b0);

		wait_window(done_at);
		check_warmup(done_at);
		read_all_freq(1'b1);
		read_word(clkmon_pkg::RD_WINDOWS, 0, clkmon_pkg::freq_t'(win_seen), 1'b0);
		read_word(clkmon_pkg::RD_ALIVE, 0, alive_mask(), 1'b0);

		for (int w = 2; w <= 3; w++) begin
			prev_done = done_at;
			wait_window(done_at);
			if (done_at - prev_done != WIN_CYCLES) begin
				stop_run($sformatf("ERR at %0d ns: window spacing %0d cycles, expected %0d",
					$time, done_at - prev_done, WIN_CYCLES));
			end
			read_all_freq(1'b1);
			read_word(clkmon_pkg::RD_WINDOWS, 0, clkmon_pkg::freq_t'(win_seen), 1'b0);
		end

		read_burst();

		// Reset in the middle of a window
		@(posedge hw);
		rst <= 1'b1;
		repeat (RESET_CYCLES) @(posedge hw);
		rst <= 1'b0;
		win_seen = 0;
		read_all_freq(1'b0);
		read_word(clkmon_pkg::RD_WINDOWS, 0, '0, 1'b0);
		wait_window(done_at);
		check_warmup(done_at);
		read_all_freq(1'b1);
		read_word(clkmon_pkg::RD_WINDOWS, 0, clkmon_pkg::freq_t'(win_seen), 1'b0);

		$display("No errors");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Errors found");
		$fatal(1, "Watchdog expired");
	end

endmodule

`default_nettype wire

//--- filelist.f
verilog/clkmon_pkg.sv
verilog/reset_sync.sv
verilog/edge_counter.sv
verilog/gray_sync.sv
verilog/freq_gate.sv
verilog/freq_regs.sv
verilog/clkmon_top.sv
bench/clkmon_tb.sv
